// File: fetch.f
+incdir+include
design/fetch_pkg.sv
design/inst_sram.sv
design/trap_csr_regs.sv
design/branch_predecode.sv
design/fetch_stage.sv
design/fetch_top.sv
testbench/tb_clk_gen.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS) include/fetch_params.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

# the log decides, not the exit code of the simulator
run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "^Regression passed" $(LOG) || { echo "pass line missing in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb;

    localparam int CLK_NS       = 4;
    localparam int RST_CYCLES   = 8;
    localparam int RUN_CYCLES   = 4000;
    // cycles of reset, load, mtvec setup and random run
    localparam int TOTAL_CYCLES = RST_CYCLES + `MEM_DEPTH + 2 + RUN_CYCLES;
    localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 200) * CLK_NS;

    logic                 clk;
    logic                 rst_n;
    logic                 stall_n;
    logic                 trap_enter;
    logic                 trap_return;
    logic                 csr_we;
    logic [`CSR_AW-1:0]   csr_addr;
    logic [`XLEN-1:0]     csr_wdata;
    logic                 mem_we;
    logic [`MEM_AW-1:0]   mem_waddr;
    logic [`XLEN-1:0]     mem_wdata;
    logic [`XLEN-1:0]     pc;
    logic [`INST_LEN-1:0] instr;
    logic                 instr_valid;

    // reference model state
    logic [`XLEN-1:0]     mem_model [`MEM_DEPTH];
    logic [`XLEN-1:0]     m_pc;
    logic [`INST_LEN-1:0] m_instr;
    logic                 m_valid;
    logic [`XLEN-1:0]     m_mtvec;
    logic [`XLEN-1:0]     m_mepc;
    logic [31:0]          rng;

    tb_clk_gen u_clk_gen (.clk_o(clk));

    fetch_top dut (
        .clk(clk), .rst_n(rst_n), .stall_n_i(stall_n),
        .trap_enter_i(trap_enter), .trap_return_i(trap_return),
        .csr_we_i(csr_we), .csr_addr_i(csr_addr), .csr_wdata_i(csr_wdata),
        .mem_we_i(mem_we), .mem_waddr_i(mem_waddr), .mem_wdata_i(mem_wdata),
        .pc_o(pc), .instr_o(instr), .instr_valid_o(instr_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // jal or branch in RISC-V bit layout
    // offset from -48 to +76 in steps of 4
    function automatic logic [31:0] make_cf(input logic [31:0] r);
        int          o;
        logic [20:0] off;
        logic [31:0] ins;
        o = (int'(r[31:27]) - 12) * 4;
        if (o == 0) begin
            o = 8;
        end
        off = o[20:0];
        if (r[26]) begin
            ins = {off[20], off[10:1], off[11], off[19:12], r[25:21], 7'h6F};
        end else begin
            ins = {off[12], off[10:5], r[25:21], r[20:16], r[15:13], off[4:1], off[11], 7'h63};
        end
        return ins;
    endfunction

    task automatic gen_instr(output logic [31:0] ins);
        rng = xorshift32(rng);
        ins = rng;
        rng = xorshift32(rng);
        // roughly one in eight becomes control flow
        // a random word with a jal or branch opcode gets a word-aligned offset too
        if (rng[2:0] == 3'd0 || ins[6:0] == 7'h6F || ins[6:0] == 7'h63) begin
            ins = make_cf(rng);
        end
    endtask

    // one clock edge of the model from the inputs now driven
    task automatic model_step();
        logic             redir;
        logic [`XLEN-1:0] tgt;
        logic [`XLEN-1:0] nxt;
        logic [`XLEN-1:0] word;
        redir = 1'b0;
        tgt   = '0;
        if (m_valid && m_instr[6:0] == 7'h6F) begin
            redir = 1'b1;
            tgt   = m_pc + {{43{m_instr[31]}}, m_instr[31], m_instr[19:12], m_instr[20],
                            m_instr[30:21], 1'b0};
        end else if (m_valid && m_instr[6:0] == 7'h63 && m_instr[31]) begin
            // backward branch is predicted taken
            redir = 1'b1;
            tgt   = m_pc + {{51{m_instr[31]}}, m_instr[31], m_instr[7], m_instr[30:25],
                            m_instr[11:8], 1'b0};
        end
        if (redir) begin
            nxt = tgt;
        end else if (trap_enter) begin
            nxt = m_mtvec;
        end else if (trap_return) begin
            nxt = m_mepc;
        end else begin
            nxt = m_pc + 64'd4;
        end
        if (csr_we && csr_addr == `CSR_MTVEC) begin
            m_mtvec = {csr_wdata[`XLEN-1:2], 2'b00};
        end
        // capture sees the pc before this edge even when stalled
        if (trap_enter) begin
            m_mepc = m_pc;
        end else if (csr_we && csr_addr == `CSR_MEPC) begin
            m_mepc = csr_wdata;
        end
        if (stall_n) begin
            word    = mem_model[nxt[10:3]];
            m_instr = nxt[2] ? word[63:32] : word[31:0];
            m_pc    = nxt;
            m_valid = 1'b1;
        end
    endtask

    task automatic check_eq(input string what, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // advance one cycle and check the outputs 1 ns after the edge
    task automatic tick();
        model_step();
        @(posedge clk);
        #1;
        check_eq("pc_o", pc, m_pc);
        check_eq("instr_o", 64'(instr), 64'(m_instr));
        check_eq("instr_valid_o", 64'(instr_valid), 64'(m_valid));
    endtask

    task automatic drive_random();
        logic [31:0] r;
        rng = xorshift32(rng);
        r   = rng;
        stall_n     = (r[2:0] != 3'd0);
        trap_enter  = (r[7:3] == 5'd0);
        trap_return = (r[12:8] == 5'd0);
        csr_we      = (r[16:13] == 4'd0);
        case (r[18:17])
            2'd0:    csr_addr = `CSR_MTVEC;
            2'd1:    csr_addr = `CSR_MEPC;
            default: csr_addr = r[30:19];
        endcase
        rng = xorshift32(rng);
        // aligned address inside the program window
        csr_wdata = 64'h8000_0000 + {53'd0, rng[10:2], 2'b00};
        // dirty low bits that mtvec has to drop
        if (csr_addr == `CSR_MTVEC) begin
            csr_wdata[1:0] = rng[12:11];
        end
    endtask

    initial begin
        logic [31:0] lo;
        logic [31:0] hi;
        rng         = 32'h34e5228a;
        rst_n       = 1'b0;
        stall_n     = 1'b0;
        trap_enter  = 1'b0;
        trap_return = 1'b0;
        csr_we      = 1'b0;
        csr_addr    = '0;
        csr_wdata   = '0;
        mem_we      = 1'b0;
        mem_waddr   = '0;
        mem_wdata   = '0;
        m_pc        = `RESET_PC;
        m_instr     = '0;
        m_valid     = 1'b0;
        m_mtvec     = '0;
        m_mepc      = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // program load while the stall holds fetch off
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            gen_instr(lo);
            gen_instr(hi);
            mem_we       = 1'b1;
            mem_waddr    = i[`MEM_AW-1:0];
            mem_wdata    = {hi, lo};
            mem_model[i] = {hi, lo};
            tick();
        end
        mem_we = 1'b0;
        rng    = xorshift32(rng);
        csr_we    = 1'b1;
        csr_addr  = `CSR_MTVEC;
        csr_wdata = 64'h8000_0000 + {53'd0, rng[10:2], 2'b11};
        tick();
        csr_we = 1'b0;
        tick();
        for (int n = 0; n < RUN_CYCLES; n++) begin
            drive_random();
            tick();
        end
        if (dut.u_fetch_stage.u_fetch_checker.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: testbench/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_checker (
    input wire logic                 clk,
    input wire logic                 rst_n,
    input wire logic                 stall_n_i,
    input wire logic                 redirect_i,
    input wire logic [`XLEN-1:0]     target_i,
    input wire logic [`XLEN-1:0]     pc_i,
    input wire logic [`INST_LEN-1:0] instr_i,
    input wire logic                 valid_i
);

    // failed assertions, read back by the testbench at the end
    int unsigned fail_cnt = 0;

    valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !valid_i)
        else begin
            fail_cnt++;
            $error("instr_valid_o high while in reset");
        end

    // no compressed or misaligned fetch
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_i[1:0] == 2'b00)
        else begin
            fail_cnt++;
            $error("pc_o not 4-byte aligned");
        end

    // stall freezes the whole output side
    hold_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !stall_n_i |=> $stable(pc_i) && $stable(instr_i) && $stable(valid_i))
        else begin
            fail_cnt++;
            $error("outputs moved during a stall");
        end

    // taken redirect lands on its target, no bubble
    redirect_lands: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_n_i && redirect_i) |=> pc_i == $past(target_i))
        else begin
            fail_cnt++;
            $error("redirect did not reach its target");
        end

endmodule

bind fetch_stage fetch_checker u_fetch_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_n_i (stall_n_i),
    .redirect_i(redirect_i),
    .target_i  (redirect_target_i),
    .pc_i      (pc_o),
    .instr_i   (instr_o),
    .valid_i   (instr_valid_o)
);

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    // half of the 4 ns period
    parameter int HALF_NS = 2
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(HALF_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: design/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 stall_n_i,
    input  wire logic                 trap_enter_i,
    input  wire logic                 trap_return_i,

    // csr write port
    input  wire logic                 csr_we_i,
    input  wire logic [`CSR_AW-1:0]   csr_addr_i,
    input  wire logic [`XLEN-1:0]     csr_wdata_i,

    // program load port
    input  wire logic                 mem_we_i,
    input  wire logic [`MEM_AW-1:0]   mem_waddr_i,
    input  wire logic [`XLEN-1:0]     mem_wdata_i,

    output logic      [`XLEN-1:0]     pc_o,
    output logic      [`INST_LEN-1:0] instr_o,
    output logic                      instr_valid_o
);

    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] mem_rdata;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic             redirect;
    logic [`XLEN-1:0] redirect_target;

    // word index from pc_next, upper bits alias
    inst_sram u_inst_sram (
        .clk         (clk),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .raddr_i     (pc_next[`MEM_AW+2:3]),
        .rdata_o     (mem_rdata)
    );

    trap_csr_regs u_trap_csr_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_we_i     (csr_we_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .trap_enter_i (trap_enter_i),
        .pc_i         (pc_o),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc)
    );

    // looks at the registered instruction, loops back combinationally
    branch_predecode u_branch_predecode (
        .instr_i       (instr_o),
        .pc_i          (pc_o),
        .instr_valid_i (instr_valid_o),
        .redirect_o    (redirect),
        .target_o      (redirect_target)
    );

    fetch_stage u_fetch_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .stall_n_i         (stall_n_i),
        .redirect_i        (redirect),
        .redirect_target_i (redirect_target),
        .trap_enter_i      (trap_enter_i),
        .trap_return_i     (trap_return_i),
        .mtvec_i           (mtvec),
        .mepc_i            (mepc),
        .mem_rdata_i       (mem_rdata),
        .pc_next_o         (pc_next),
        .pc_o              (pc_o),
        .instr_o           (instr_o),
        .instr_valid_o     (instr_valid_o)
    );

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_stage import fetch_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 stall_n_i,

    // predecode redirect
    input  wire logic                 redirect_i,
    input  wire logic [`XLEN-1:0]     redirect_target_i,

    // trap control, single-cycle pulses
    input  wire logic                 trap_enter_i,
    input  wire logic                 trap_return_i,
    input  wire logic [`XLEN-1:0]     mtvec_i,
    input  wire logic [`XLEN-1:0]     mepc_i,

    // memory word at pc_next
    input  wire logic [`XLEN-1:0]     mem_rdata_i,

    output logic      [`XLEN-1:0]     pc_next_o,
    output logic      [`XLEN-1:0]     pc_o,
    output logic      [`INST_LEN-1:0] instr_o,
    output logic                      instr_valid_o
);

    logic [`INST_LEN-1:0] instr_sel;

    // next pc, fixed priority
    // redirect, then trap entry, then trap return, then sequential
    always_comb begin
        if (redirect_i) begin
            pc_next_o = redirect_target_i;
        end else if (trap_enter_i) begin
            pc_next_o = mtvec_i;
        end else if (trap_return_i) begin
            pc_next_o = mepc_i;
        end else begin
            pc_next_o = pc_o + `XLEN'd4;
        end
    end

    // bit 2 of the fetch address picks the half
    assign instr_sel = sel_half(mem_rdata_i, pc_next_o[2]);

    // pc and instruction move together
    // a stall freezes both, valid too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o          <= `RESET_PC;
            instr_o       <= '0;
            instr_valid_o <= 1'b0;
        end else if (stall_n_i) begin
            pc_o          <= pc_next_o;
            instr_o       <= instr_sel;
            // memory read never fails, so valid sticks after the first fetch
            instr_valid_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/branch_predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module branch_predecode import fetch_pkg::*; (
    // registered instruction and its pc
    input  wire logic [`INST_LEN-1:0] instr_i,
    input  wire logic [`XLEN-1:0]     pc_i,
    input  wire logic                 instr_valid_i,

    // back to the next-pc mux, same cycle
    output logic                      redirect_o,
    output logic      [`XLEN-1:0]     target_o
);

    instr_word_u      iw;
    logic             is_jal;
    logic             is_branch;
    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] b_imm;

    assign iw = instr_word_u'(instr_i);

    // opcode picks which view means something
    assign is_jal    = instr_valid_i && (iw.j_view.opcode == OP_JAL);
    assign is_branch = instr_valid_i && (iw.b_view.opcode == OP_BRANCH);

    // J immediate, bit 0 always zero
    assign j_imm = {{(`XLEN-21){iw.j_view.imm20}},
                    iw.j_view.imm20,
                    iw.j_view.imm19_12,
                    iw.j_view.imm11,
                    iw.j_view.imm10_1,
                    1'b0};

    // B immediate, same sign extension
    assign b_imm = {{(`XLEN-13){iw.b_view.imm12}},
                    iw.b_view.imm12,
                    iw.b_view.imm11,
                    iw.b_view.imm10_5,
                    iw.b_view.imm4_1,
                    1'b0};

    // jal always taken
    // branch taken only backwards, imm12 is the sign
    assign redirect_o = is_jal || (is_branch && iw.b_view.imm12);

    // target only matters when redirect_o is set
    assign target_o = pc_i + (is_jal ? j_imm : b_imm);

endmodule

`default_nettype wire

// File: design/trap_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module trap_csr_regs import fetch_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,

    // csr write strobe
    input  wire logic               csr_we_i,
    input  wire logic [`CSR_AW-1:0] csr_addr_i,
    input  wire logic [`XLEN-1:0]   csr_wdata_i,

    // trap entry, captures the current pc
    input  wire logic               trap_enter_i,
    input  wire logic [`XLEN-1:0]   pc_i,

    output logic      [`XLEN-1:0]   mtvec_o,
    output logic      [`XLEN-1:0]   mepc_o
);

    logic wr_mtvec;
    logic wr_mepc;

    // address match, other numbers ignored
    assign wr_mtvec = csr_we_i && (csr_addr_i == `CSR_MTVEC);
    assign wr_mepc  = csr_we_i && (csr_addr_i == `CSR_MEPC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_o <= '0;
            mepc_o  <= '0;
        end else begin
            if (wr_mtvec) begin
                mtvec_o <= mtvec_direct(csr_wdata_i);
            end
            // trap capture beats a software write
            // capture also happens during a stall
            if (trap_enter_i) begin
                mepc_o <= pc_i;
            end else if (wr_mepc) begin
                mepc_o <= csr_wdata_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/inst_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module inst_sram (
    input  wire logic               clk,

    // load port, one word per strobe
    input  wire logic               mem_we_i,
    input  wire logic [`MEM_AW-1:0] mem_waddr_i,
    input  wire logic [`XLEN-1:0]   mem_wdata_i,

    // fetch read port
    input  wire logic [`MEM_AW-1:0] raddr_i,
    output logic      [`XLEN-1:0]   rdata_o
);

    // plain register array
    logic [`XLEN-1:0] mem [`MEM_DEPTH];

    // load write lands at the next edge
    always_ff @(posedge clk) begin
        if (mem_we_i) begin
            mem[mem_waddr_i] <= mem_wdata_i;
        end
    end

    // asynchronous read
    // follows pc_next within the same cycle
    assign rdata_o = mem[raddr_i];

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    // major opcodes the predecoder cares about
    typedef enum logic [6:0] {
        OP_BRANCH = 7'h63,
        OP_JAL    = 7'h6F
    } opcode_e;

    // one fetched word, seen as J-type and as B-type
    // opcode field sits at the same place in both views
    typedef union packed {
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            opcode_e    opcode;
        } j_view;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            opcode_e    opcode;
        } b_view;
    } instr_word_u;

    // upper or lower instruction of a 64-bit memory word
    function automatic logic [`INST_LEN-1:0] sel_half(input logic [`XLEN-1:0] word,
                                                      input logic hi);
        return hi ? word[`XLEN-1:`INST_LEN] : word[`INST_LEN-1:0];
    endfunction

    // direct mode only, low two bits read as zero
    function automatic logic [`XLEN-1:0] mtvec_direct(input logic [`XLEN-1:0] value);
        return {value[`XLEN-1:2], 2'b00};
    endfunction

endpackage

`default_nettype wire

// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// datapath width: pc, csrs, memory words
`define XLEN 64

// one uncompressed instruction
`define INST_LEN 32

// pc register value out of reset
// the first fetched address is 8000_0000
`define RESET_PC (64'h8000_0000 - 64'd4)

// memory word address width, 256 x 64 bit
`define MEM_AW 8
`define MEM_DEPTH (1 << `MEM_AW)

// csr numbers on the write port
`define CSR_AW 12
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341

`endif
